/* src/frontend_cfg.svh */
// Front end configuration macros: queue depths, reset PC and data path width
`ifndef FRONTEND_CFG_SVH
`define FRONTEND_CFG_SVH

// Instruction queue entries between fetch and decode
`define FE_IQ_DEPTH 8

// Micro-op queue entries between decode and the back end
`define FE_UQ_DEPTH 4

// First fetch address after reset
`define FE_RESET_PC 32'h0000_0000

// PC and instruction width
`define FE_XLEN 32

`endif

/* src/frontend_pkg.sv */
// Front end types: fetch entry, operation class and decoded micro-op
`default_nettype none
`include "frontend_cfg.svh"

package frontend_pkg;

    // One fetched word with its own and its sequential PC
    typedef struct packed {
        logic [`FE_XLEN-1:0] pc;
        logic [`FE_XLEN-1:0] next_pc;
        logic [`FE_XLEN-1:0] instr;
    } fetch_entry_t;

    // Coarse class from the major opcode
    typedef enum logic [3:0] {
        alu_reg,
        alu_imm,
        load,
        store,
        branch,
        jal,
        jalr,
        lui,
        auipc,
        system,
        illegal
    } op_class_e;

    // Decoded micro-op handed to the back end
    typedef struct packed {
        logic [`FE_XLEN-1:0] pc;
        op_class_e           op_class;
        logic [2:0]          funct3;
        // Bit 30 of the word, selects SUB and SRA
        logic                funct7_b5;
        logic [4:0]          rd;
        logic [4:0]          rs1;
        logic [4:0]          rs2;
        // Already sign extended, zero for R-type and illegal
        logic [`FE_XLEN-1:0] imm;
    } uop_t;

endpackage : frontend_pkg

`default_nettype wire

/* src/fetch_if.sv */
// Fetch to instruction queue interface with fetch and queue modports
`default_nettype none
`timescale 1ns/100ps

interface fetch_if;

    // Write strobe, one entry per cycle
    logic                      wr;
    frontend_pkg::fetch_entry_t entry;
    // Queue has no free slot
    logic                      full;
    // Redirect, empties the queue at the next edge
    logic                      flush;

    modport fetch (
        output wr,
        output entry,
        input  full,
        input  flush
    );

    modport queue (
        input  wr,
        input  entry,
        input  flush,
        output full
    );

endinterface : fetch_if

`default_nettype wire

/* src/fetch_unit.sv */
// Fetch unit: PC generation, instruction memory requests and queue writes
`default_nettype none
`timescale 1ns/100ps
`include "frontend_cfg.svh"

module fetch_unit (
    input  logic                clk,
    input  logic                i_arst_n,
    input  logic                i_redirect,
    input  logic [`FE_XLEN-1:0] i_redirect_pc,
    output logic                o_imem_req,
    output logic [`FE_XLEN-1:0] o_imem_addr,
    input  logic                i_imem_resp,
    input  logic [`FE_XLEN-1:0] i_imem_rdata,
    fetch_if.fetch              fetch
);

    logic [`FE_XLEN-1:0] pc_q;
    logic [`FE_XLEN-1:0] addr_q;
    logic                req_q;
    logic                pending_q;
    logic                drop_q;
    logic                issue;
    logic                accept;

    // Only one request in flight, and only with a free queue slot
    assign issue  = !pending_q && !fetch.full && !i_redirect;
    // Response that still belongs to the current path
    assign accept = i_imem_resp && pending_q && !drop_q;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc_q      <= `FE_RESET_PC;
            addr_q    <= `FE_RESET_PC;
            req_q     <= 1'b0;
            pending_q <= 1'b0;
            drop_q    <= 1'b0;
        end else begin
            req_q <= issue;
            if (issue) begin
                addr_q    <= pc_q;
                pending_q <= 1'b1;
            end else if (i_imem_resp && pending_q) begin
                pending_q <= 1'b0;
                drop_q    <= 1'b0;
            end
            if (i_redirect) begin
                pc_q <= i_redirect_pc;
                // Old request outlives this edge, so its word is stale
                if (pending_q && !i_imem_resp) begin
                    drop_q <= 1'b1;
                end
            end else if (accept) begin
                pc_q <= pc_q + `FE_XLEN'd4;
            end
        end
    end

    assign o_imem_req  = req_q;
    assign o_imem_addr = addr_q;

    // Word goes into the queue in the response cycle
    assign fetch.wr            = accept && !fetch.flush;
    assign fetch.entry.pc      = pc_q;
    assign fetch.entry.next_pc = pc_q + `FE_XLEN'd4;
    assign fetch.entry.instr   = i_imem_rdata;

endmodule : fetch_unit

`default_nettype wire

/* src/i_queue.sv */
// Circular FIFO with flush, occupancy count and registered pop output
`default_nettype none
`timescale 1ns/100ps

module i_queue #(
    parameter type T_DATA = logic [7:0],
    parameter int  DEPTH  = 4
) (
    input  logic                         clk,
    input  logic                         i_arst_n,
    input  logic                         i_flush,
    input  logic                         i_wr,
    input  T_DATA                        i_data,
    output logic                         o_full,
    input  logic                         i_rd,
    output T_DATA                        o_data,
    output logic                         o_valid,
    output logic                         o_empty,
    output logic [$clog2(DEPTH+1)-1:0]   o_count
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    T_DATA          mem [DEPTH];
    logic [AW-1:0]  head_q;
    logic [AW-1:0]  tail_q;
    logic [CW-1:0]  count_q;
    logic           do_wr;
    logic           do_rd;

    // Pointer step with wrap for depths that are not a power of two
    function automatic logic [AW-1:0] ptr_next(input logic [AW-1:0] ptr);
        ptr_next = (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign o_full  = (count_q == CW'(DEPTH));
    assign o_empty = (count_q == '0);
    assign o_count = count_q;

    // Overflow and underflow attempts are dropped
    assign do_wr = i_wr && !o_full && !i_flush;
    assign do_rd = i_rd && !o_empty && !i_flush;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            o_valid <= 1'b0;
        end else if (i_flush) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            o_valid <= 1'b0;
        end else begin
            if (do_wr) begin
                tail_q <= ptr_next(tail_q);
            end
            if (do_rd) begin
                head_q <= ptr_next(head_q);
            end
            // Simultaneous push and pop leave the count alone
            count_q <= count_q + CW'(do_wr) - CW'(do_rd);
            o_valid <= do_rd;
        end
    end

    // Storage and output word
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[tail_q] <= i_data;
        end
        // Output only moves on a pop
        if (do_rd) begin
            o_data <= mem[head_q];
        end
    end

endmodule : i_queue

`default_nettype wire

/* src/rv32i_decoder.sv */
// RV32I decoder: pops fetch entries and writes registered micro-ops
`default_nettype none
`timescale 1ns/100ps
`include "frontend_cfg.svh"

module rv32i_decoder (
    input  logic                                clk,
    input  logic                                i_arst_n,
    input  logic                                i_flush,
    output logic                                o_iq_rd,
    input  frontend_pkg::fetch_entry_t          i_iq_data,
    input  logic                                i_iq_valid,
    input  logic                                i_iq_empty,
    output logic                                o_uq_wr,
    output frontend_pkg::uop_t                  o_uq_data,
    input  logic [$clog2(`FE_UQ_DEPTH+1)-1:0]   i_uq_count
);

    localparam int CW = $clog2(`FE_UQ_DEPTH + 1);

    logic [`FE_XLEN-1:0] instr;
    logic [CW:0]         in_flight;
    frontend_pkg::uop_t  uop;

    // Popped entry arriving now plus micro-op being written now
    assign in_flight = (CW+1)'(i_iq_valid) + (CW+1)'(o_uq_wr);

    // Pop only if the result is sure to find a free micro-op slot
    assign o_iq_rd = !i_iq_empty && !i_flush
                     && ((CW+1)'(i_uq_count) + in_flight < (CW+1)'(`FE_UQ_DEPTH));

    assign instr = i_iq_data.instr;

    always_comb begin
        uop           = '0;
        uop.pc        = i_iq_data.pc;
        uop.funct3    = instr[14:12];
        uop.funct7_b5 = instr[30];
        uop.rd        = instr[11:7];
        uop.rs1       = instr[19:15];
        uop.rs2       = instr[24:20];
        case (instr[6:0])
            7'b0110011: uop.op_class = frontend_pkg::alu_reg;
            7'b0010011: uop.op_class = frontend_pkg::alu_imm;
            7'b0000011: uop.op_class = frontend_pkg::load;
            7'b0100011: uop.op_class = frontend_pkg::store;
            7'b1100011: uop.op_class = frontend_pkg::branch;
            7'b1101111: uop.op_class = frontend_pkg::jal;
            7'b1100111: uop.op_class = frontend_pkg::jalr;
            7'b0110111: uop.op_class = frontend_pkg::lui;
            7'b0010111: uop.op_class = frontend_pkg::auipc;
            7'b1110011: uop.op_class = frontend_pkg::system;
            default:    uop.op_class = frontend_pkg::illegal;
        endcase
        // Immediate format follows the class
        case (uop.op_class)
            frontend_pkg::alu_imm, frontend_pkg::load,
            frontend_pkg::jalr, frontend_pkg::system:
                uop.imm = {{20{instr[31]}}, instr[31:20]};
            frontend_pkg::store:
                uop.imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            frontend_pkg::branch:
                uop.imm = {{19{instr[31]}}, instr[31], instr[7],
                           instr[30:25], instr[11:8], 1'b0};
            frontend_pkg::lui, frontend_pkg::auipc:
                uop.imm = {instr[31:12], 12'b0};
            frontend_pkg::jal:
                uop.imm = {{11{instr[31]}}, instr[31], instr[19:12],
                           instr[20], instr[30:21], 1'b0};
            default:
                uop.imm = '0;
        endcase
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_uq_wr <= 1'b0;
        end else begin
            // Entry popped before a redirect is dropped here
            o_uq_wr <= i_iq_valid && !i_flush;
        end
    end

    always_ff @(posedge clk) begin
        if (i_iq_valid) begin
            o_uq_data <= uop;
        end
    end

endmodule : rv32i_decoder

`default_nettype wire

/* src/frontend_top.sv */
// Front end top: fetch unit, instruction queue, decoder and micro-op queue
`default_nettype none
`timescale 1ns/100ps
`include "frontend_cfg.svh"

module frontend_top (
    input  logic                    clk,
    input  logic                    i_arst_n,
    input  logic                    i_redirect,
    input  logic [`FE_XLEN-1:0]     i_redirect_pc,
    output logic                    o_imem_req,
    output logic [`FE_XLEN-1:0]     o_imem_addr,
    input  logic                    i_imem_resp,
    input  logic [`FE_XLEN-1:0]     i_imem_rdata,
    input  logic                    i_uop_read,
    output logic                    o_uop_valid,
    output logic [`FE_XLEN-1:0]     o_uop_pc,
    output frontend_pkg::op_class_e o_uop_class,
    output logic [4:0]              o_uop_rd,
    output logic [4:0]              o_uop_rs1,
    output logic [4:0]              o_uop_rs2,
    output logic [`FE_XLEN-1:0]     o_uop_imm,
    output logic                    o_uop_empty
);

    fetch_if u_fetch_if ();

    logic                                      iq_rd;
    frontend_pkg::fetch_entry_t                iq_data;
    logic                                      iq_valid;
    logic                                      iq_empty;
    logic                                      uq_wr;
    frontend_pkg::uop_t                        uq_wdata;
    frontend_pkg::uop_t                        uq_rdata;
    logic [$clog2(`FE_UQ_DEPTH+1)-1:0]         uq_count;

    assign u_fetch_if.flush = i_redirect;

    fetch_unit u_fetch (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .i_redirect    (i_redirect),
        .i_redirect_pc (i_redirect_pc),
        .o_imem_req    (o_imem_req),
        .o_imem_addr   (o_imem_addr),
        .i_imem_resp   (i_imem_resp),
        .i_imem_rdata  (i_imem_rdata),
        .fetch         (u_fetch_if.fetch)
    );

    // Fetched words waiting for decode
    i_queue #(
        .T_DATA (frontend_pkg::fetch_entry_t),
        .DEPTH  (`FE_IQ_DEPTH)
    ) u_iq (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_flush  (u_fetch_if.flush),
        .i_wr     (u_fetch_if.wr),
        .i_data   (u_fetch_if.entry),
        .o_full   (u_fetch_if.full),
        .i_rd     (iq_rd),
        .o_data   (iq_data),
        .o_valid  (iq_valid),
        .o_empty  (iq_empty),
        .o_count  ()
    );

    rv32i_decoder u_dec (
        .clk        (clk),
        .i_arst_n   (i_arst_n),
        .i_flush    (i_redirect),
        .o_iq_rd    (iq_rd),
        .i_iq_data  (iq_data),
        .i_iq_valid (iq_valid),
        .i_iq_empty (iq_empty),
        .o_uq_wr    (uq_wr),
        .o_uq_data  (uq_wdata),
        .i_uq_count (uq_count)
    );

    // Decoded micro-ops for the back end
    i_queue #(
        .T_DATA (frontend_pkg::uop_t),
        .DEPTH  (`FE_UQ_DEPTH)
    ) u_uq (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_flush  (i_redirect),
        .i_wr     (uq_wr),
        .i_data   (uq_wdata),
        .o_full   (),
        .i_rd     (i_uop_read),
        .o_data   (uq_rdata),
        .o_valid  (o_uop_valid),
        .o_empty  (o_uop_empty),
        .o_count  (uq_count)
    );

    assign o_uop_pc    = uq_rdata.pc;
    assign o_uop_class = uq_rdata.op_class;
    assign o_uop_rd    = uq_rdata.rd;
    assign o_uop_rs1   = uq_rdata.rs1;
    assign o_uop_rs2   = uq_rdata.rs2;
    assign o_uop_imm   = uq_rdata.imm;

endmodule : frontend_top

`default_nettype wire

/* verif/frontend_chk.sv */
// Queue protocol assertions, bound into every i_queue instance
`default_nettype none
`timescale 1ns/100ps

module frontend_chk #(
    parameter int DEPTH = 4
) (
    input  logic                         clk,
    input  logic                         i_arst_n,
    input  logic                         i_flush,
    input  logic                         i_wr,
    input  logic                         o_full,
    input  logic                         i_rd,
    input  logic                         o_valid,
    input  logic                         o_empty,
    input  logic [$clog2(DEPTH+1)-1:0]   o_count
);

    localparam int CW = $clog2(DEPTH + 1);

    // Producer has to honor full
    no_write_when_full: assert property (@(posedge clk) disable iff (!i_arst_n)
        !(i_wr && o_full && !i_flush))
        else $error("queue written while full");

    // Consumer has to honor empty
    no_read_when_empty: assert property (@(posedge clk) disable iff (!i_arst_n)
        !(i_rd && o_empty && !i_flush))
        else $error("queue read while empty");

    count_in_range: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_count <= CW'(DEPTH))
        else $error("queue count above depth");

    // Strobe only right after an accepted pop
    valid_after_read: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_valid |-> $past(i_rd && !o_empty && !i_flush))
        else $error("queue valid without a pop one cycle before");

endmodule : frontend_chk

`default_nettype wire

/* verif/frontend_tb.sv */
// Front end testbench with memory model, consumer, redirects, reference decoder and checker
`default_nettype none
`timescale 1ns/100ps
`include "frontend_cfg.svh"

module frontend_tb;

    localparam int UOP_TIMEOUT   = 3000;
    localparam int REDIR_TIMEOUT = 10;

    logic                    clk;
    logic                    i_arst_n;
    logic                    i_redirect;
    logic [`FE_XLEN-1:0]     i_redirect_pc;
    logic                    o_imem_req;
    logic [`FE_XLEN-1:0]     o_imem_addr;
    logic                    i_imem_resp;
    logic [`FE_XLEN-1:0]     i_imem_rdata;
    logic                    i_uop_read;
    logic                    o_uop_valid;
    logic [`FE_XLEN-1:0]     o_uop_pc;
    frontend_pkg::op_class_e o_uop_class;
    logic [4:0]              o_uop_rd;
    logic [4:0]              o_uop_rs1;
    logic [4:0]              o_uop_rs2;
    logic [`FE_XLEN-1:0]     o_uop_imm;
    logic                    o_uop_empty;

    logic [31:0] prog [64];
    logic [31:0] rng;
    logic [31:0] exp_pc;
    logic [31:0] mem_addr;
    logic [2:0]  mem_wait;
    logic        mem_busy;
    logic        run;
    logic        stall;
    logic        redir_pend;
    logic [31:0] redir_target;
    logic        abort;
    logic        read_prev;
    logic        class_seen [11];
    frontend_pkg::op_class_e report_class;
    int          n_err;
    int          n_checked;

    frontend_top dut (.*);

    bind i_queue frontend_chk #(.DEPTH(DEPTH)) u_chk (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_flush  (i_flush),
        .i_wr     (i_wr),
        .o_full   (o_full),
        .i_rd     (i_rd),
        .o_valid  (o_valid),
        .o_empty  (o_empty),
        .o_count  (o_count)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Expected micro-op from the RV32I encoding rules
    function automatic frontend_pkg::uop_t decode_ref(input logic [31:0] addr,
                                                      input logic [31:0] w);
        frontend_pkg::uop_t u;
        logic [11:0] s_imm;
        logic [12:0] b_imm;
        logic [20:0] j_imm;
        s_imm = {w[31:25], w[11:7]};
        b_imm = {w[31], w[7], w[30:25], w[11:8], 1'b0};
        j_imm = {w[31], w[19:12], w[20], w[30:21], 1'b0};
        u = '0;
        u.pc = addr;
        u.funct3 = w[14:12];
        u.funct7_b5 = w[30];
        u.rd = w[11:7];
        u.rs1 = w[19:15];
        u.rs2 = w[24:20];
        u.op_class = frontend_pkg::illegal;
        case (w[6:0])
            7'h33: u.op_class = frontend_pkg::alu_reg;
            7'h13: u.op_class = frontend_pkg::alu_imm;
            7'h03: u.op_class = frontend_pkg::load;
            7'h67: u.op_class = frontend_pkg::jalr;
            7'h73: u.op_class = frontend_pkg::system;
            7'h23: u.op_class = frontend_pkg::store;
            7'h63: u.op_class = frontend_pkg::branch;
            7'h37: u.op_class = frontend_pkg::lui;
            7'h17: u.op_class = frontend_pkg::auipc;
            7'h6f: u.op_class = frontend_pkg::jal;
            default: u.op_class = frontend_pkg::illegal;
        endcase
        case (w[6:0])
            7'h13, 7'h03, 7'h67, 7'h73: u.imm = $signed(w) >>> 20;
            7'h23: u.imm = 32'($signed(s_imm));
            7'h63: u.imm = 32'($signed(b_imm));
            7'h37, 7'h17: u.imm = w & 32'hffff_f000;
            7'h6f: u.imm = 32'($signed(j_imm));
            default: u.imm = '0;
        endcase
        return u;
    endfunction

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] want);
        assert (got === want) else begin
            n_err++;
            $display("[ERROR] %0t %s: got 0x%08h, expected 0x%08h", $time, name, got, want);
        end
    endtask

    task automatic check_uop();
        frontend_pkg::uop_t want;
        want = decode_ref(exp_pc, prog[exp_pc[7:2]]);
        compare_word("o_uop_pc", o_uop_pc, want.pc);
        compare_word("o_uop_class", 32'(o_uop_class), 32'(want.op_class));
        compare_word("o_uop_rd", 32'(o_uop_rd), 32'(want.rd));
        compare_word("o_uop_rs1", 32'(o_uop_rs1), 32'(want.rs1));
        compare_word("o_uop_rs2", 32'(o_uop_rs2), 32'(want.rs2));
        compare_word("o_uop_imm", o_uop_imm, want.imm);
        // A class is covered only once the DUT delivered it correctly
        if (o_uop_class == want.op_class) begin
            class_seen[int'(want.op_class)] = 1'b1;
        end
        exp_pc = exp_pc + 32'd4;
        n_checked++;
    endtask

    // Legal opcodes in most words and bit 0 cleared in every 16th word
    task automatic fill_program();
        logic [6:0] legal_ops [10];
        legal_ops = '{7'h33, 7'h13, 7'h03, 7'h23, 7'h63, 7'h6f, 7'h67, 7'h37, 7'h17, 7'h73};
        for (int i = 0; i < 64; i++) begin
            rng = xorshift32(rng);
            if (i % 16 == 15) begin
                prog[i] = {rng[31:1], 1'b0};
            end else begin
                prog[i] = {rng[31:7], legal_ops[i % 10]};
            end
        end
    endtask

    task automatic wait_uops(input int n);
        int target;
        int cycles;
        target = n_checked + n;
        cycles = 0;
        while (!abort && n_checked < target) begin
            @(posedge clk);
            cycles++;
            if (cycles > UOP_TIMEOUT) begin
                n_err++;
                abort = 1'b1;
                $display("Timeout: only %0d of %0d micro-ops arrived", n_checked, target);
            end
        end
    endtask

    task automatic redirect_to(input logic [31:0] pc);
        int cycles;
        cycles = 0;
        redir_target = pc;
        redir_pend = 1'b1;
        while (!abort && redir_pend) begin
            @(posedge clk);
            cycles++;
            if (cycles > REDIR_TIMEOUT) begin
                n_err++;
                abort = 1'b1;
                $display("Timeout: redirect to 0x%08h was never driven", pc);
            end
        end
    endtask

    task automatic finish_run();
        $display("Checked %0d micro-ops, %0d errors", n_checked, n_err);
        if (n_err == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    endtask

    // Memory model, compare, consumer and redirect in one process
    always @(negedge clk) begin
        if (run) begin
            i_imem_resp = 1'b0;
            if (mem_busy) begin
                if (mem_wait == 3'd0) begin
                    i_imem_resp = 1'b1;
                    i_imem_rdata = prog[mem_addr[7:2]];
                    mem_busy = 1'b0;
                end else begin
                    mem_wait = mem_wait - 3'd1;
                end
            end else if (o_imem_req) begin
                rng = xorshift32(rng);
                mem_wait = 3'(rng % 32'd6);
                mem_addr = o_imem_addr;
                mem_busy = 1'b1;
            end
            // One valid cycle follows each read of a non-empty queue
            compare_word("o_uop_valid", 32'(o_uop_valid), 32'(read_prev));
            // Old path is still checked before the new PC takes over
            if (o_uop_valid) begin
                check_uop();
            end
            rng = xorshift32(rng);
            i_uop_read = !o_uop_empty && !stall && (rng[1:0] != 2'b00);
            i_redirect = redir_pend;
            if (redir_pend) begin
                i_redirect_pc = redir_target;
                exp_pc = redir_target;
                redir_pend = 1'b0;
            end
            // Flush in the same cycle cancels the read
            read_prev = i_uop_read && !i_redirect;
        end
    end

    initial begin
        clk = 1'b0;
        i_arst_n = 1'b0;
        i_redirect = 1'b0;
        i_redirect_pc = '0;
        i_imem_resp = 1'b0;
        i_imem_rdata = '0;
        i_uop_read = 1'b0;
        rng = 32'd2811;
        exp_pc = `FE_RESET_PC;
        mem_addr = '0;
        mem_wait = '0;
        mem_busy = 1'b0;
        run = 1'b0;
        stall = 1'b0;
        redir_pend = 1'b0;
        redir_target = '0;
        abort = 1'b0;
        read_prev = 1'b0;
        report_class = frontend_pkg::alu_reg;
        n_err = 0;
        n_checked = 0;
        foreach (class_seen[c]) class_seen[c] = 1'b0;
        fill_program();
        repeat (8) @(posedge clk);
        @(negedge clk);
        i_arst_n = 1'b1;
        assert (!o_imem_req && !o_uop_valid && o_uop_empty) else begin
            n_err++;
            $display("Outputs are not idle after reset");
        end
        @(posedge clk);
        run = 1'b1;
        // Program order from the reset PC
        wait_uops(150);
        // Slow back end lets both queues fill
        stall = 1'b1;
        repeat (40) @(posedge clk);
        assert (!o_uop_empty) else begin
            n_err++;
            $display("Micro-op queue still empty after the back end stalled");
        end
        stall = 1'b0;
        wait_uops(40);
        redirect_to(32'h0000_0080);
        wait_uops(60);
        // Redirect with both queues full
        stall = 1'b1;
        repeat (30) @(posedge clk);
        redirect_to(32'h0000_1f04);
        stall = 1'b0;
        wait_uops(60);
        for (int c = 0; c < 11; c++) begin
            report_class = frontend_pkg::op_class_e'(c);
            assert (abort || class_seen[c]) else begin
                n_err++;
                $display("Op class %s never reached the back end", report_class.name());
            end
        end
        finish_run();
    end

endmodule : frontend_tb

`default_nettype wire

/* sources.f */
+incdir+src
src/frontend_pkg.sv
src/fetch_if.sv
src/fetch_unit.sv
src/i_queue.sv
src/rv32i_decoder.sv
src/frontend_top.sv
verif/frontend_chk.sv
verif/frontend_tb.sv

/* Makefile */
# Verilator build and run of the front end testbench

VERILATOR  ?= verilator
TOP        ?= frontend_tb
FILELIST   ?= sources.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --timing --assert
FAIL_MSG   ?= ERRORS FOUND

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
